// ==== uopPkg.sv ====
// Shared types and encodings for the micro-op sequencer. Rz reuses R15 so split instructions must not read R15 as data
package uopPkg;

	typedef logic [31:0] instrWordT; // Instruction or micro-op word
	typedef logic [3:0]  regIdxT;    // Register index
	typedef logic [15:0] regListT;   // Load-multiple register list

	// Instruction classes seen by the sequencer
	typedef enum logic [2:0] {
		passThru,   // Single micro-op, unchanged
		rsrOp,      // Register-shifted-register data processing
		mlaShort,   // Short multiply-accumulate
		branchLink, // Branch with link
		loadMult    // Load-multiple with nonempty list
	} opClassT;

	// Sequencer states, also tag each step for the builder
	typedef enum logic [2:0] {
		ready,      // First micro-op or pass-through
		rsr,        // Operation on Rz after the shift
		multiply,   // Add after the multiply into Rz
		bl,         // Plain branch after the link move
		ldm         // One word load per listed register
	} seqStateT;

	// Data-processing opcodes used by the split micro-ops
	typedef enum logic [3:0] {
		addOpc = 4'b0100,
		movOpc = 4'b1101
	} dpOpcT;

	localparam regIdxT rzIdx   = 4'd15; // Scratch register
	localparam regIdxT linkIdx = 4'd14; // Link register
	localparam regIdxT pcIdx   = 4'd15; // Program counter

	// Control struct sent with every micro-op
	typedef struct packed {
		logic rzWrite;      // Destination is Rz
		logic rzRead;       // Rz used as an operand
		logic noFlagUpdate; // Hold the flags
		logic keepV;        // Keep the overflow flag
		logic prevRsr;      // Second half of an RSR split
		logic ldmForward;   // Load-multiple micro-op after the first
		logic lastUop;      // Final micro-op of its instruction
	} uopCtrlT;

	// Load-multiple summary from the decoder
	typedef struct packed {
		logic [4:0]  regCount; // Set bits in the list
		logic        startUp;  // Start offset is zero or positive
		logic [11:0] startMag; // Start offset magnitude in bytes
	} ldmInfoT;

	// One step from the sequencer to the builder
	typedef struct packed {
		seqStateT   state;  // Class state of this step
		instrWordT  instr;  // Instruction being split
		regIdxT     ldmReg; // Register loaded by this step
		logic [4:0] k;      // Micro-op index within the instruction
		ldmInfoT    ldm;    // Count and start offset
	} seqStepT;

endpackage

// ==== instrDecode.sv ====
// Combinational classifier for the held instruction. Empty-list loads and store-multiple are pass-through
`timescale 1ns/1ns

module instrDecode import uopPkg::*; (
	input  instrWordT instr,
	output opClassT   opClass,
	output ldmInfoT   ldmInfo
);

	logic       isRsr;     // Register-shifted-register form
	logic       isMla;     // Short accumulate form
	logic       isLdm;     // Load-multiple with registers
	logic       isBl;      // Branch with link
	logic [4:0] setCount;  // Registers in the list
	logic [6:0] listBytes; // Four bytes per register
	logic [6:0] lessOne;   // Four bytes per register minus one word

	assign isRsr = (instr[27:25] == 3'b000) && !instr[7] && instr[4];
	assign isMla = (instr[27:22] == 6'b000000) && instr[21] && (instr[7:4] == 4'b1001);
	assign isLdm = (instr[27:25] == 3'b100) && instr[20] && (instr[15:0] != 16'h0000);
	assign isBl = (instr[27:24] == 4'b1011);

	// Population count of the register list
	always_comb begin
		setCount = 5'd0;
		for (int i = 0; i < 16; i++) begin
			setCount = setCount + {4'd0, instr[i]};
		end
	end

	assign listBytes = {setCount, 2'b00};
	assign lessOne = {setCount - 5'd1, 2'b00}; // Only read when the list is nonempty

	// Fixed priority, RSR first
	always_comb begin
		if (isRsr)
			opClass = rsrOp;
		else if (isMla)
			opClass = mlaShort;
		else if (isLdm)
			opClass = loadMult;
		else if (isBl)
			opClass = branchLink;
		else
			opClass = passThru;
	end

	// Start offset from the P and U bits
	always_comb begin
		ldmInfo.regCount = setCount;
		case (instr[24:23])
			2'b01: begin // Increment after
				ldmInfo.startUp = 1'b1;
				ldmInfo.startMag = 12'd0;
			end
			2'b11: begin // Increment before
				ldmInfo.startUp = 1'b1;
				ldmInfo.startMag = 12'd4;
			end
			2'b00: begin // Decrement after, 4 - 4n
				ldmInfo.startUp = (setCount == 5'd1); // Zero counts as up
				ldmInfo.startMag = {5'd0, lessOne};
			end
			default: begin // Decrement before, -4n
				ldmInfo.startUp = 1'b0;
				ldmInfo.startMag = {5'd0, listBytes};
			end
		endcase
	end

endmodule

// ==== uopSequencer.sv ====
// Holds one instruction and issues its steps in order. The first step bypasses the holding register when empty
`timescale 1ns/1ns

module uopSequencer import uopPkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      instrValid,
	input  instrWordT instr,
	output logic      instrReady,
	output instrWordT heldInstr,
	input  opClassT   opClass,
	input  ldmInfoT   ldmInfo,
	output logic      stepValid,
	output seqStepT   step,
	input  logic      stepReady
);

	seqStateT   state;       // Next step of the held instruction
	logic       busy;        // Holding register is occupied
	instrWordT  heldReg;
	regListT    remList;     // Loads still to issue
	logic [4:0] kCnt;        // Steps already issued
	regListT    curList;
	regListT    clearedList; // Current list without its lowest bit
	seqStateT   classState;
	logic       lastStep;
	logic       stepFire;
	logic       accept;
	logic       loadHeld;

	// Index of the lowest set bit, zero for an empty list
	function automatic regIdxT lowestReg(input regListT list);
		regIdxT idx;
		idx = '0;
		for (int i = 15; i >= 0; i--) begin
			if (list[i])
				idx = regIdxT'(i);
		end
		return idx;
	endfunction

	assign heldInstr = busy ? heldReg : instr; // Bypass when empty
	assign curList = (state == ldm) ? remList : heldInstr[15:0];
	assign clearedList = curList & (curList - 16'd1);

	always_comb begin
		case (opClass)
			rsrOp:      classState = rsr;
			mlaShort:   classState = multiply;
			branchLink: classState = bl;
			loadMult:   classState = ldm;
			default:    classState = ready;
		endcase
	end

	always_comb begin
		case (state)
			ready:   lastStep = (classState == ready) ||
				((classState == ldm) && (clearedList == '0)); // Pass-through or single load
			ldm:     lastStep = (clearedList == '0);
			default: lastStep = 1'b1; // Second half of a split
		endcase
	end

	assign stepValid = busy || instrValid;
	assign stepFire = stepValid && stepReady;
	assign instrReady = !busy || (lastStep && stepReady);
	assign accept = instrValid && instrReady;
	assign loadHeld = accept && (busy || !(stepFire && lastStep)); // Keep unless fully issued

	always_comb begin
		step.state = (state == ready) ? classState : state;
		step.instr = heldInstr;
		step.ldmReg = lowestReg(curList);
		step.k = kCnt;
		step.ldm = ldmInfo;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ready;
			busy <= 1'b0;
			remList <= '0;
			kCnt <= 5'd0;
		end else begin
			busy <= loadHeld || (busy && !(stepFire && lastStep));
			if (stepFire) begin
				state <= lastStep ? ready : step.state;
				remList <= clearedList; // Lowest register done
				kCnt <= lastStep ? 5'd0 : kCnt + 5'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (loadHeld)
			heldReg <= instr;
	end

	// A load step always has a register left to load
	ldmListLive: assert property (@(posedge clk) disable iff (reset)
		(stepValid && state == ldm) |-> (remList != '0));

	stateLegal: assert property (@(posedge clk) disable iff (reset)
		state inside {ready, rsr, multiply, bl, ldm});

endmodule

// ==== uopBuilder.sv ====
// Forms each micro-op from a step and holds it in a single output register. Load offsets stay within 12 bits
`timescale 1ns/1ns

module uopBuilder import uopPkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      stepValid,
	input  seqStepT   step,
	output logic      stepReady,
	output logic      uopValid,
	output instrWordT uop,
	output uopCtrlT   uopCtrl,
	input  logic      uopReady
);

	instrWordT          si;        // Instruction of the step
	logic [3:0]         cond;
	logic               firstHalf; // First micro-op of a split
	logic signed [13:0] startOff;
	logic signed [13:0] loadOff;   // s + 4k
	logic [13:0]        loadMag;
	logic               loadUp;
	instrWordT          nextUop;
	uopCtrlT            nextCtrl;

	assign si = step.instr;
	assign cond = si[31:28];
	assign firstHalf = (step.k == 5'd0);

	// Signed load offset for this k
	assign startOff = step.ldm.startUp ? $signed({2'b00, step.ldm.startMag})
		: -$signed({2'b00, step.ldm.startMag});
	assign loadOff = startOff + $signed({7'd0, step.k, 2'b00});
	assign loadUp = !loadOff[13];
	assign loadMag = loadUp ? loadOff : -loadOff;

	always_comb begin
		nextUop = si;
		nextCtrl = '0;
		case (step.state)
			rsr: begin
				if (firstHalf) begin // Shift into Rz
					nextUop = {si[31:25], movOpc, 1'b0, 4'd0, rzIdx, si[11:0]};
					nextCtrl.rzWrite = 1'b1;
					nextCtrl.noFlagUpdate = 1'b1;
				end else begin // Operate on Rz unshifted
					nextUop = {si[31:12], 8'd0, rzIdx};
					nextCtrl.rzRead = 1'b1;
					nextCtrl.prevRsr = 1'b1;
					nextCtrl.lastUop = 1'b1;
				end
			end
			multiply: begin
				if (firstHalf) begin // Plain multiply into Rz
					nextUop = {si[31:22], 2'b00, rzIdx, 4'd0, si[11:0]};
					nextCtrl.rzWrite = 1'b1;
					nextCtrl.keepV = 1'b1;
				end else begin // Rd = Rz + Rn
					nextUop = {cond, 3'b000, addOpc, si[20], rzIdx, si[19:16], 8'd0, si[15:12]};
					nextCtrl.rzRead = 1'b1;
					nextCtrl.lastUop = 1'b1;
				end
			end
			bl: begin
				if (firstHalf) begin
					nextUop = {cond, 3'b000, movOpc, 1'b0, 4'd0, linkIdx, 8'd0, pcIdx}; // R14 = R15
				end else begin
					nextUop = {si[31:25], 1'b0, si[23:0]}; // Link bit cleared
					nextCtrl.lastUop = 1'b1;
				end
			end
			ldm: begin // Pre-indexed word load, no writeback
				nextUop = {cond, 3'b010, 1'b1, loadUp, 1'b0, 1'b0, 1'b1, si[19:16], step.ldmReg,
					loadMag[11:0]};
				nextCtrl.noFlagUpdate = 1'b1;
				nextCtrl.ldmForward = !firstHalf;
				nextCtrl.lastUop = (step.k == step.ldm.regCount - 5'd1);
			end
			default: begin
				nextCtrl.lastUop = 1'b1; // Pass-through
			end
		endcase
	end

	// Take a step when empty or draining
	assign stepReady = !uopValid || uopReady;

	always_ff @(posedge clk) begin
		if (reset)
			uopValid <= 1'b0;
		else
			uopValid <= stepValid || (uopValid && !uopReady);
	end

	always_ff @(posedge clk) begin
		if (stepValid && stepReady) begin
			uop <= nextUop;
			uopCtrl <= nextCtrl;
		end
	end

	// Stalled output holds its value
	uopHold: assert property (@(posedge clk) disable iff (reset)
		(uopValid && !uopReady) |=> (uopValid && $stable(uop) && $stable(uopCtrl)));

endmodule

// ==== uopTop.sv ====
// Micro-op sequencer top level. One instruction can wait in the sequencer while another drains the output
`timescale 1ns/1ns

module uopTop import uopPkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      instrValid,
	input  instrWordT instr,
	output logic      instrReady,
	output logic      uopValid,
	output instrWordT uop,
	output uopCtrlT   uopCtrl,
	input  logic      uopReady
);

	instrWordT heldInstr; // Instruction under decode
	opClassT   opClass;
	ldmInfoT   ldmInfo;
	logic      stepValid;
	logic      stepReady;
	seqStepT   step;

	instrDecode decode (
		.instr   (heldInstr),
		.opClass (opClass),
		.ldmInfo (ldmInfo)
	);

	uopSequencer sequencer (
		.clk        (clk),
		.reset      (reset),
		.instrValid (instrValid),
		.instr      (instr),
		.instrReady (instrReady),
		.heldInstr  (heldInstr),
		.opClass    (opClass),
		.ldmInfo    (ldmInfo),
		.stepValid  (stepValid),
		.step       (step),
		.stepReady  (stepReady)
	);

	uopBuilder builder (
		.clk       (clk),
		.reset     (reset),
		.stepValid (stepValid),
		.step      (step),
		.stepReady (stepReady),
		.uopValid  (uopValid),
		.uop       (uop),
		.uopCtrl   (uopCtrl),
		.uopReady  (uopReady)
	);

endmodule

// ==== tbUopModel.svh ====
// Expected micro-op model, included inside a module that imports uopPkg. Keeps one queue per result kind
`ifndef TB_UOP_MODEL_SVH
`define TB_UOP_MODEL_SVH

instrWordT expUop[$];  // Expected words, oldest first
uopCtrlT   expCtrl[$]; // Matching control structs

function automatic uopCtrlT makeCtrl(input logic rzWrite, input logic rzRead,
	input logic noFlag, input logic keepV, input logic prevRsr, input logic ldmForward,
	input logic lastUop);
	uopCtrlT c;
	c.rzWrite = rzWrite;
	c.rzRead = rzRead;
	c.noFlagUpdate = noFlag;
	c.keepV = keepV;
	c.prevRsr = prevRsr;
	c.ldmForward = ldmForward;
	c.lastUop = lastUop;
	return c;
endfunction

task automatic pushUop(input instrWordT w, input uopCtrlT c);
	expUop.push_back(w);
	expCtrl.push_back(c);
endtask

// Expands one accepted instruction into its micro-ops, checked in priority order
task automatic expandInstr(input instrWordT w);
	instrWordT  m;
	logic [3:0] cond;
	logic       up;
	int         n;
	int         s;
	int         o;
	int         k;
	int         r;
	cond = w[31:28];
	m = w;
	n = 0;
	k = 0;
	if (w[27:25] == 3'b000 && !w[7] && w[4]) begin // Shift into Rz, then operate on Rz
		pushUop({w[31:25], movOpc, 1'b0, 4'h0, rzIdx, w[11:0]},
			makeCtrl(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
		pushUop({w[31:12], 8'h00, rzIdx}, makeCtrl(1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1));
	end else if (w[27:22] == 6'd0 && w[21] && w[7:4] == 4'b1001) begin // Multiply, then add
		m[21:20] = 2'b00;
		m[19:16] = rzIdx;
		m[15:12] = 4'h0;
		pushUop(m, makeCtrl(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0));
		pushUop({cond, 3'b000, addOpc, w[20], rzIdx, w[19:16], 8'h00, w[15:12]},
			makeCtrl(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1));
	end else if (w[27:25] == 3'b100 && w[20] && w[15:0] != 16'h0000) begin
		for (r = 0; r < 16; r++) begin
			if (w[r])
				n++;
		end
		case (w[24:23]) // Start offset from the addressing mode
			2'b01: s = 0;
			2'b11: s = 4;
			2'b00: s = 4 - 4 * n;
			default: s = -4 * n;
		endcase
		for (r = 0; r < 16; r++) begin
			if (w[r]) begin // Ascending register order
				o = s + 4 * k;
				up = (o >= 0);
				if (o < 0)
					o = -o;
				pushUop({cond, 3'b010, 1'b1, up, 1'b0, 1'b0, 1'b1, w[19:16], 4'(r), 12'(o)},
					makeCtrl(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, (k >= 1), (k == n - 1)));
				k++;
			end
		end
	end else if (w[27:24] == 4'b1011) begin // Link move, then plain branch
		pushUop({cond, 3'b000, movOpc, 1'b0, 4'h0, linkIdx, 8'h00, pcIdx}, '0);
		m[24] = 1'b0;
		pushUop(m, makeCtrl(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1));
	end else begin
		pushUop(w, makeCtrl(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1)); // Unchanged
	end
endtask

`endif

// ==== tbUopTop.sv ====
// Directed timing run then 600 random instructions under back-pressure. Outputs sampled on the falling edge
`timescale 1ns/1ns

module tbUopTop import uopPkg::*; ();

	localparam int numInstr = 600;                         // Random instructions
	localparam int dirCount = 8;                           // Directed back-to-back run
	localparam int timeoutLimit = numInstr * 17 * 4 + 100; // Cycles before giving up

	logic      clk;
	logic      reset;
	logic      instrValid;
	instrWordT instr;
	logic      instrReady;
	logic      uopValid;
	instrWordT uop;
	uopCtrlT   uopCtrl;
	logic      uopReady;

	logic inAccepted;       // Input transfer on the coming edge
	logic pressureOn;       // Random uopReady drops
	int   mismatchCount;
	int   otherErrors;
	int   monCycle;
	int   uopCount;
	int   acceptCount;
	int   firstAcceptCycle;
	int   firstValidCycle;
	int   dirDoneCycle;     // Cycle of the last directed micro-op
	int   timeoutCycles;

	`include "tbUopModel.svh"

	uopTop dut (
		.clk        (clk),
		.reset      (reset),
		.instrValid (instrValid),
		.instr      (instr),
		.instrReady (instrReady),
		.uopValid   (uopValid),
		.uop        (uop),
		.uopCtrl    (uopCtrl),
		.uopReady   (uopReady)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	task automatic checkUop(input instrWordT got, input instrWordT exp);
		if (got !== exp) begin
			mismatchCount++;
			$display("MISMATCH uop at %0t: got %h expected %h", $time, got, exp);
		end
	endtask

	task automatic checkCtrl(input uopCtrlT got, input uopCtrlT exp);
		if (got !== exp) begin
			mismatchCount++;
			$display("MISMATCH uopCtrl at %0t: got %h expected %h", $time, got, exp);
		end
	endtask

	// One rising edge, then a fresh uopReady
	task automatic nextCycle();
		@(posedge clk);
		if (pressureOn)
			uopReady <= ($urandom_range(0, 3) != 0); // Ready about three cycles in four
		else
			uopReady <= 1'b1;
	endtask

	task automatic sendInstr(input instrWordT w, input logic mayDrop);
		while (mayDrop && ($urandom_range(0, 3) == 0)) begin
			instrValid <= 1'b0; // Idle cycle before the word
			nextCycle();
		end
		instrValid <= 1'b1;
		instr <= w;
		nextCycle();
		while (!inAccepted)
			nextCycle(); // Word held until taken
	endtask

	task automatic waitDrain();
		int waited;
		waited = 0;
		while (expUop.size() != 0 && waited < 400) begin
			nextCycle();
			waited++;
		end
		repeat (4) nextCycle(); // Stray micro-ops show up here
	endtask

	// Random instruction of one kind, 0 to 6
	function automatic instrWordT genInstr(input int kind);
		instrWordT w;
		regListT   list;
		w = $urandom;
		list = 16'($urandom);
		case (kind)
			0: w[27:26] = 2'b01; // Single load or store
			1: begin // Register-shifted register
				w[27:25] = 3'b000;
				w[7] = 1'b0;
				w[4] = 1'b1;
			end
			2: begin // Short multiply-accumulate
				w[27:21] = 7'b0000001;
				w[7:4] = 4'b1001;
			end
			3: w[27:24] = 4'b1011; // Branch with link
			4: begin // Load-multiple, any mode
				if ($urandom_range(0, 1) == 1)
					list = list & 16'($urandom); // Sparser lists
				if (list == '0)
					list = 16'd1 << $urandom_range(0, 15);
				w[27:25] = 3'b100;
				w[20] = 1'b1;
				w[15:0] = list;
			end
			5: begin // Store-multiple
				w[27:25] = 3'b100;
				w[20] = 1'b0;
			end
			default: begin // Load-multiple with empty list
				w[27:25] = 3'b100;
				w[20] = 1'b1;
				w[15:0] = '0;
			end
		endcase
		return w;
	endfunction

	// Monitor on the falling edge, where all DUT signals are settled
	always @(negedge clk) begin
		if (reset) begin
			inAccepted = 1'b0;
		end else begin
			monCycle++;
			inAccepted = instrValid && instrReady;
			if (uopValid && firstValidCycle < 0)
				firstValidCycle = monCycle;
			if (uopValid && uopReady) begin
				if (expUop.size() == 0) begin
					otherErrors++;
					$display("ERROR at %0t: micro-op %h came out with none expected", $time, uop);
				end else begin
					checkUop(uop, expUop.pop_front());
					checkCtrl(uopCtrl, expCtrl.pop_front());
				end
				uopCount++;
				if (uopCount == dirCount)
					dirDoneCycle = monCycle;
			end
			if (inAccepted) begin
				if (acceptCount == 0)
					firstAcceptCycle = monCycle;
				acceptCount++;
				expandInstr(instr);
			end
		end
	end

	initial begin
		timeoutCycles = 0;
		while (timeoutCycles < timeoutLimit) begin
			@(posedge clk);
			timeoutCycles++;
		end
		$display("ERROR: run did not finish within %0d cycles", timeoutLimit);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		int i;
		void'($urandom(85164));
		reset <= 1'b1;
		instrValid <= 1'b0;
		instr <= '0;
		uopReady <= 1'b1;
		pressureOn = 1'b0;
		mismatchCount = 0;
		otherErrors = 0;
		monCycle = 0;
		uopCount = 0;
		acceptCount = 0;
		firstAcceptCycle = -1;
		firstValidCycle = -1;
		dirDoneCycle = -1;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		if (uopValid !== 1'b0 || instrReady !== 1'b1) begin
			otherErrors++;
			$display("ERROR: after reset uopValid is %b and instrReady is %b", uopValid, instrReady);
		end
		nextCycle();
		for (i = 0; i < dirCount; i++)
			sendInstr(genInstr(0), 1'b0); // Back to back, uopReady high
		instrValid <= 1'b0;
		waitDrain();
		if (firstValidCycle != firstAcceptCycle + 1) begin
			otherErrors++;
			$display("ERROR: first micro-op did not appear one cycle after the first accept");
		end
		if (dirDoneCycle != firstAcceptCycle + dirCount) begin
			otherErrors++;
			$display("ERROR: directed micro-ops did not come out one per cycle");
		end
		pressureOn = 1'b1;
		for (i = 0; i < numInstr; i++)
			sendInstr(genInstr(int'($urandom_range(0, 6))), 1'b1);
		instrValid <= 1'b0;
		waitDrain();
		if (expUop.size() != 0) begin
			otherErrors++;
			$display("ERROR: %0d expected micro-ops never came out", expUop.size());
		end
		$display("Errors: %0d mismatches, %0d other", mismatchCount, otherErrors);
		if (mismatchCount == 0 && otherErrors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== uopTop.f ====
+incdir+.
uopPkg.sv
instrDecode.sv
uopSequencer.sv
uopBuilder.sv
uopTop.sv
tbUopTop.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the micro-op sequencer testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tbUopTop -f uopTop.f -o simUop
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/simUop > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
	exit 1
fi
exit 0
